// File: rtl/bridge_pkg.sv
package bridge_pkg;

	////////////////////
	// Serial timing
	////////////////////

	// 50 MHz / 115200 baud, rounded
	localparam int baud_div = 434;
	localparam int baud_w = $clog2(baud_div);
	// Last count of a full and of a half bit period
	localparam logic [baud_w-1:0] baud_last = baud_w'(baud_div - 1);
	localparam logic [baud_w-1:0] baud_half_last = baud_w'(baud_div / 2 - 1);

	////////////////////
	// Register file
	////////////////////

	localparam int reg_count = 16;
	localparam int reg_aw = $clog2(reg_count);

	// Receiver states
	localparam logic [1:0] rx_idle = 2'd0;
	localparam logic [1:0] rx_start = 2'd1;
	localparam logic [1:0] rx_data = 2'd2;
	localparam logic [1:0] rx_stop = 2'd3;

	// Transmitter states
	localparam logic tx_idle = 1'b0;
	localparam logic tx_send = 1'b1;

	// Frame states
	localparam logic [2:0] fr_idle = 3'd0;
	localparam logic [2:0] fr_wait_addr = 3'd1;
	localparam logic [2:0] fr_wait_data = 3'd2;
	localparam logic [2:0] fr_access = 3'd3;
	localparam logic [2:0] fr_send_addr = 3'd4;
	localparam logic [2:0] fr_wait_addr_sent = 3'd5;
	localparam logic [2:0] fr_send_data = 3'd6;
	localparam logic [2:0] fr_wait_data_sent = 3'd7;

	// Command byte, bit 0 selects read
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [6:0] reserved;
			logic rd;
		} fields;
	} cmd_byte_u;

endpackage

// File: rtl/baud_timer.sv
`timescale 1ns/100ps

module baud_timer (
	input logic CLK_50MHZ,
	input logic arst_n,
	input logic run,
	input logic half,
	output logic tick
);

	// Bit period counter
	logic [bridge_pkg::baud_w-1:0] cnt;
	// High until the first interval has ended
	logic first;
	logic [bridge_pkg::baud_w-1:0] last;

	// Short first interval only when asked for
	assign last = (first && half) ? bridge_pkg::baud_half_last : bridge_pkg::baud_last;
	assign tick = run && (cnt == last);

	always_ff @(posedge CLK_50MHZ or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			first <= 1'b1;
		end else if (!run) begin
			// Idle, restart from a clean count
			cnt <= '0;
			first <= 1'b1;
		end else if (tick) begin
			cnt <= '0;
			first <= 1'b0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

// File: rtl/uart_rx.sv
`timescale 1ns/100ps

module uart_rx (
	input logic CLK_50MHZ,
	input logic arst_n,
	input logic rx,
	output logic [7:0] data,
	output logic valid
);

	////////////////////
	// Input sync
	////////////////////

	logic rx_meta;
	logic rx_sync;
	// Previous synced level for edge detect
	logic rx_prev;
	logic rx_fall;

	always_ff @(posedge CLK_50MHZ or negedge arst_n) begin
		if (!arst_n) begin
			// Line idles high
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign rx_fall = rx_prev && !rx_sync;

	////////////////////
	// Bit timing
	////////////////////

	logic [1:0] state;
	logic run;
	logic half;
	logic tick;

	// Timer runs for the whole byte, mid-bit ticks
	assign run = (state != bridge_pkg::rx_idle);
	// Half period only until the start bit center
	assign half = (state == bridge_pkg::rx_start);

	baud_timer baud_i (
		.CLK_50MHZ(CLK_50MHZ),
		.arst_n(arst_n),
		.run(run),
		.half(half),
		.tick(tick)
	);

	////////////////////
	// Receive FSM
	////////////////////

	logic [7:0] shreg;
	logic [2:0] bit_cnt;

	always_ff @(posedge CLK_50MHZ or negedge arst_n) begin
		if (!arst_n) begin
			state <= bridge_pkg::rx_idle;
			bit_cnt <= '0;
			valid <= 1'b0;
		end else begin
			valid <= 1'b0;
			case (state)
				bridge_pkg::rx_idle: begin
					if (rx_fall) begin
						state <= bridge_pkg::rx_start;
					end
				end
				bridge_pkg::rx_start: begin
					// Recheck start bit at its center
					if (tick) begin
						bit_cnt <= '0;
						state <= rx_sync ? bridge_pkg::rx_idle : bridge_pkg::rx_data;
					end
				end
				bridge_pkg::rx_data: begin
					if (tick) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= bridge_pkg::rx_stop;
						end
					end
				end
				default: begin
					// Low stop bit means framing error, byte dropped
					if (tick) begin
						valid <= rx_sync;
						state <= bridge_pkg::rx_idle;
					end
				end
			endcase
		end
	end

	// LSB arrives first, shift in from the top
	always_ff @(posedge CLK_50MHZ) begin
		if (state == bridge_pkg::rx_data && tick) begin
			shreg <= {rx_sync, shreg[7:1]};
		end
	end

	// Shift register holds still until the next start bit
	assign data = shreg;

endmodule

// File: rtl/uart_tx.sv
`timescale 1ns/100ps

module uart_tx (
	input logic CLK_50MHZ,
	input logic arst_n,
	input logic [7:0] data,
	input logic start,
	output logic busy,
	output logic tx
);

	logic state;
	logic tick;
	// Stop bit plus data, the start bit goes straight to tx
	logic [8:0] shreg;
	// Bit periods completed
	logic [3:0] bit_cnt;

	baud_timer baud_i (
		.CLK_50MHZ(CLK_50MHZ),
		.arst_n(arst_n),
		.run(state == bridge_pkg::tx_send),
		.half(1'b0),
		.tick(tick)
	);

	////////////////////
	// Transmit FSM
	////////////////////

	always_ff @(posedge CLK_50MHZ or negedge arst_n) begin
		if (!arst_n) begin
			state <= bridge_pkg::tx_idle;
			busy <= 1'b0;
			tx <= 1'b1;
			bit_cnt <= '0;
		end else begin
			case (state)
				bridge_pkg::tx_idle: begin
					if (start) begin
						// Start bit from the next cycle on
						tx <= 1'b0;
						busy <= 1'b1;
						bit_cnt <= '0;
						state <= bridge_pkg::tx_send;
					end
				end
				default: begin
					if (tick) begin
						if (bit_cnt == 4'd9) begin
							// Stop bit has had its full period
							busy <= 1'b0;
							state <= bridge_pkg::tx_idle;
						end else begin
							tx <= shreg[0];
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
			endcase
		end
	end

	// Frame payload, LSB first then stop
	always_ff @(posedge CLK_50MHZ) begin
		if (state == bridge_pkg::tx_idle && start) begin
			shreg <= {1'b1, data};
		end else if (state == bridge_pkg::tx_send && tick) begin
			shreg <= {1'b1, shreg[8:1]};
		end
	end

endmodule

// File: rtl/frame_fsm.sv
`timescale 1ns/100ps

module frame_fsm (
	input logic CLK_50MHZ,
	input logic arst_n,
	input logic [7:0] rx_data,
	input logic rx_valid,
	input logic tx_busy,
	input logic [7:0] reg_rdata,
	output logic tx_start,
	output logic [7:0] tx_data,
	output logic [7:0] reg_addr,
	output logic [7:0] reg_wdata,
	output logic reg_we,
	output logic reg_re
);

	logic [2:0] state;
	// Frame bytes as received
	bridge_pkg::cmd_byte_u cmd_q;
	logic [7:0] addr_q;
	logic [7:0] data_q;

	////////////////////
	// Frame FSM
	////////////////////

	always_ff @(posedge CLK_50MHZ or negedge arst_n) begin
		if (!arst_n) begin
			state <= bridge_pkg::fr_idle;
		end else begin
			case (state)
				bridge_pkg::fr_idle: begin
					if (rx_valid) begin
						state <= bridge_pkg::fr_wait_addr;
					end
				end
				bridge_pkg::fr_wait_addr: begin
					if (rx_valid) begin
						state <= bridge_pkg::fr_wait_data;
					end
				end
				bridge_pkg::fr_wait_data: begin
					if (rx_valid) begin
						state <= bridge_pkg::fr_access;
					end
				end
				bridge_pkg::fr_access: begin
					// Writes end here, reads go on to the reply
					state <= cmd_q.fields.rd ? bridge_pkg::fr_send_addr : bridge_pkg::fr_idle;
				end
				bridge_pkg::fr_send_addr: begin
					state <= bridge_pkg::fr_wait_addr_sent;
				end
				bridge_pkg::fr_wait_addr_sent: begin
					// busy is already high here, wait for its fall
					if (!tx_busy) begin
						state <= bridge_pkg::fr_send_data;
					end
				end
				bridge_pkg::fr_send_data: begin
					state <= bridge_pkg::fr_wait_data_sent;
				end
				default: begin
					if (!tx_busy) begin
						state <= bridge_pkg::fr_idle;
					end
				end
			endcase
		end
	end

	// Capture each byte in its own slot
	always_ff @(posedge CLK_50MHZ) begin
		if (rx_valid) begin
			if (state == bridge_pkg::fr_idle) begin
				cmd_q.raw <= rx_data;
			end
			if (state == bridge_pkg::fr_wait_addr) begin
				addr_q <= rx_data;
			end
			if (state == bridge_pkg::fr_wait_data) begin
				data_q <= rx_data;
			end
		end
	end

	////////////////////
	// Strobes
	////////////////////

	// Reserved command bits play no part
	assign reg_we = (state == bridge_pkg::fr_access) && !cmd_q.fields.rd;
	assign reg_re = (state == bridge_pkg::fr_access) && cmd_q.fields.rd;
	assign reg_addr = addr_q;
	assign reg_wdata = data_q;

	// Address echo first, then the read value
	assign tx_start = (state == bridge_pkg::fr_send_addr) || (state == bridge_pkg::fr_send_data);
	assign tx_data = (state == bridge_pkg::fr_send_data) ? reg_rdata : addr_q;

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/100ps

module reg_file (
	input logic CLK_50MHZ,
	input logic arst_n,
	input logic [7:0] addr,
	input logic [7:0] wdata,
	input logic we,
	input logic re,
	output logic [7:0] rdata
);

	logic [7:0] regs [bridge_pkg::reg_count];
	logic in_range;
	logic [bridge_pkg::reg_aw-1:0] idx;

	// Upper addresses fall outside the file
	assign in_range = (int'(addr) < bridge_pkg::reg_count);
	assign idx = addr[bridge_pkg::reg_aw-1:0];

	// Storage, out of range writes are lost
	always_ff @(posedge CLK_50MHZ or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < bridge_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (we && in_range) begin
			regs[idx] <= wdata;
		end
	end

	// Registered read port
	always_ff @(posedge CLK_50MHZ or negedge arst_n) begin
		if (!arst_n) begin
			rdata <= '0;
		end else if (re) begin
			// Zero for anything beyond the file
			rdata <= in_range ? regs[idx] : 8'h00;
		end
	end

endmodule

// File: rtl/bridge_top.sv
`timescale 1ns/100ps

module bridge_top (
	input logic CLK_50MHZ,
	input logic arst_n,
	input logic rx,
	output logic tx
);

	// Receive side
	logic [7:0] rx_data;
	logic rx_valid;
	// Transmit side
	logic [7:0] tx_data;
	logic tx_start;
	logic tx_busy;
	// Register access
	logic [7:0] reg_addr;
	logic [7:0] reg_wdata;
	logic [7:0] reg_rdata;
	logic reg_we;
	logic reg_re;

	uart_rx rx_i (
		.CLK_50MHZ(CLK_50MHZ),
		.arst_n(arst_n),
		.rx(rx),
		.data(rx_data),
		.valid(rx_valid)
	);

	uart_tx tx_i (
		.CLK_50MHZ(CLK_50MHZ),
		.arst_n(arst_n),
		.data(tx_data),
		.start(tx_start),
		.busy(tx_busy),
		.tx(tx)
	);

	frame_fsm fsm_i (
		.CLK_50MHZ(CLK_50MHZ),
		.arst_n(arst_n),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.tx_busy(tx_busy),
		.reg_rdata(reg_rdata),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_we(reg_we),
		.reg_re(reg_re)
	);

	reg_file regs_i (
		.CLK_50MHZ(CLK_50MHZ),
		.arst_n(arst_n),
		.addr(reg_addr),
		.wdata(reg_wdata),
		.we(reg_we),
		.re(reg_re),
		.rdata(reg_rdata)
	);

endmodule

// File: test/bridge_tb.sv
`timescale 1ns/100ps

module bridge_tb;

	logic CLK_50MHZ;
	logic arst_n;
	logic rx;
	logic tx;

	// Register model and pending reply bytes
	logic [7:0] model [bridge_pkg::reg_count];
	logic [7:0] exp_addr [$];
	logic [7:0] exp_data [$];
	logic [31:0] lcg_seed;
	int replies_done;
	int checks;
	int errors;
	int test_errors;

	bridge_top dut_i (
		.CLK_50MHZ(CLK_50MHZ),
		.arst_n(arst_n),
		.rx(rx),
		.tx(tx)
	);

	// 50 MHz
	always #10 CLK_50MHZ = ~CLK_50MHZ;

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [7:0] rand_byte();
		lcg_seed = lcg_seed * 32'd1664525 + 32'd1013904223;
		return lcg_seed[23:16];
	endfunction

	// Expected read value is zero outside the file
	function automatic logic [7:0] expected_read(input logic [7:0] addr);
		if (int'(addr) < bridge_pkg::reg_count) begin
			return model[addr[bridge_pkg::reg_aw-1:0]];
		end
		return 8'h00;
	endfunction

	function automatic logic [7:0] make_cmd(input logic rd, input logic [6:0] rsv);
		bridge_pkg::cmd_byte_u cmd;
		cmd.fields.reserved = rsv;
		cmd.fields.rd = rd;
		return cmd.raw;
	endfunction

	// One 8N1 byte on rx with an optional low stop bit
	task automatic send_byte(input logic [7:0] b, input bit bad_stop);
		@(negedge CLK_50MHZ);
		rx = 1'b0;
		repeat (bridge_pkg::baud_div) @(negedge CLK_50MHZ);
		for (int i = 0; i < 8; i++) begin
			rx = b[i];
			repeat (bridge_pkg::baud_div) @(negedge CLK_50MHZ);
		end
		rx = !bad_stop;
		repeat (bridge_pkg::baud_div) @(negedge CLK_50MHZ);
		// Back to idle with one extra bit time after a bad stop
		rx = 1'b1;
		if (bad_stop) begin
			repeat (bridge_pkg::baud_div) @(negedge CLK_50MHZ);
		end
	endtask

	// Catch one byte on tx by mid-bit samples
	task automatic receive_byte(input int limit, output logic [7:0] b, output logic stop,
			output bit ok);
		int cnt;
		cnt = 0;
		b = '0;
		stop = 1'b0;
		while (tx !== 1'b0 && cnt < limit) begin
			@(negedge CLK_50MHZ);
			cnt++;
		end
		ok = (tx === 1'b0);
		if (ok) begin
			// Center of start bit
			repeat (bridge_pkg::baud_div / 2) @(negedge CLK_50MHZ);
			for (int i = 0; i < 8; i++) begin
				repeat (bridge_pkg::baud_div) @(negedge CLK_50MHZ);
				b[i] = tx;
			end
			repeat (bridge_pkg::baud_div) @(negedge CLK_50MHZ);
			stop = tx;
		end
	endtask

	task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] got,
			input logic stop);
		checks++;
		assert (got === exp) else begin
			$display("error: %s expected %h got %h", name, exp, got);
			errors++;
		end
		assert (stop === 1'b1) else begin
			$display("error: %s stop bit expected 1 got %h", name, stop);
			errors++;
		end
	endtask

	////////////////////
	// Frames
	////////////////////

	// Junk byte with low stop may sit before the data byte
	task automatic write_frame(input logic [7:0] addr, input logic [7:0] data,
			input logic [6:0] rsv, input bit junk);
		send_byte(make_cmd(1'b0, rsv), 1'b0);
		send_byte(addr, 1'b0);
		if (junk) begin
			send_byte(rand_byte(), 1'b1);
		end
		send_byte(data, 1'b0);
		if (int'(addr) < bridge_pkg::reg_count) begin
			model[addr[bridge_pkg::reg_aw-1:0]] = data;
		end
	endtask

	task automatic read_frame(input logic [7:0] addr, input logic [6:0] rsv);
		int target;
		int cnt;
		target = replies_done + 1;
		cnt = 0;
		// Queue before sending since the reply starts inside the last stop bit
		exp_addr.push_back(addr);
		exp_data.push_back(expected_read(addr));
		send_byte(make_cmd(1'b1, rsv), 1'b0);
		send_byte(addr, 1'b0);
		send_byte(rand_byte(), 1'b0);
		while (replies_done < target && cnt < 60 * bridge_pkg::baud_div) begin
			@(negedge CLK_50MHZ);
			cnt++;
		end
		if (replies_done < target) begin
			$display("timeout: read reply for address %h never completed", addr);
			errors++;
		end
	endtask

	// tx must stay high for the given number of cycles
	task automatic check_tx_quiet(input int cycles, input string what);
		bit seen;
		seen = 1'b0;
		for (int i = 0; i < cycles; i++) begin
			@(negedge CLK_50MHZ);
			if (tx !== 1'b1) begin
				seen = 1'b1;
			end
		end
		checks++;
		assert (!seen) else begin
			$display("tx went low %s", what);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		$display("test %s: %s, %0d errors", name, (errors == test_errors) ? "pass" : "fail",
			errors - test_errors);
		test_errors = errors;
	endtask

	////////////////////
	// Reply checker
	////////////////////

	initial begin : compare_proc
		logic [7:0] got;
		logic stop;
		bit ok;
		forever begin
			@(posedge CLK_50MHZ);
			if (exp_addr.size() != 0) begin
				receive_byte(40 * bridge_pkg::baud_div, got, stop, ok);
				if (ok) begin
					compare_byte("tx_addr", exp_addr[0], got, stop);
					// Second byte follows right after the first
					receive_byte(4 * bridge_pkg::baud_div, got, stop, ok);
					if (ok) begin
						compare_byte("tx_data", exp_data[0], got, stop);
					end else begin
						$display("timeout: second reply byte never started on tx");
						errors++;
					end
				end else begin
					$display("timeout: no reply started on tx");
					errors++;
				end
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
				// Rest of the stop bit until the bridge is idle
				repeat (bridge_pkg::baud_div / 2 + 8) @(negedge CLK_50MHZ);
				replies_done++;
			end
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		logic [7:0] addrs [8];
		logic [7:0] a;
		logic [7:0] d;
		CLK_50MHZ = 1'b0;
		arst_n = 1'b0;
		rx = 1'b1;
		lcg_seed = 32'h6d24;
		replies_done = 0;
		checks = 0;
		errors = 0;
		test_errors = 0;
		for (int i = 0; i < bridge_pkg::reg_count; i++) begin
			model[i] = 8'h00;
		end
		repeat (2) @(negedge CLK_50MHZ);
		arst_n = 1'b1;

		// Idle line and then every register reads zero
		check_tx_quiet(4 * bridge_pkg::baud_div, "while idle after reset");
		for (int i = 0; i < bridge_pkg::reg_count; i++) begin
			read_frame(8'(i), 7'h00);
		end
		report_test("reset values");

		for (int i = 0; i < 8; i++) begin
			addrs[i] = 8'(rand_byte() % bridge_pkg::reg_count);
			write_frame(addrs[i], rand_byte(), 7'h00, 1'b0);
		end
		for (int i = 0; i < 8; i++) begin
			read_frame(addrs[i], 7'h00);
		end
		report_test("random write and read");

		// Out of range write and the aliased low entry
		a = 8'(16 + rand_byte() % 240);
		write_frame(a, rand_byte(), 7'h00, 1'b0);
		read_frame(a, 7'h00);
		read_frame(a & 8'h0f, 7'h00);
		read_frame(8'h0f, 7'h00);
		read_frame(8'h00, 7'h00);
		report_test("out of range address");

		for (int i = 0; i < 8; i++) begin
			a = 8'(rand_byte() % bridge_pkg::reg_count);
			d = rand_byte();
			write_frame(a, d, 7'(rand_byte() >> 1), 1'b0);
			read_frame(a, 7'(rand_byte() >> 1));
		end
		report_test("reserved command bits");

		// Lone bad byte and then one inside a write frame
		send_byte(rand_byte(), 1'b1);
		a = 8'(rand_byte() % bridge_pkg::reg_count);
		write_frame(a, rand_byte(), 7'h00, 1'b1);
		read_frame(a, 7'h00);
		report_test("framing error");

		write_frame(8'(rand_byte() % bridge_pkg::reg_count), rand_byte(), 7'h00, 1'b0);
		check_tx_quiet(30 * bridge_pkg::baud_div, "after a write frame");
		report_test("no reply on write");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: sim.f
rtl/bridge_pkg.sv
rtl/baud_timer.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/frame_fsm.sv
rtl/reg_file.sv
rtl/bridge_top.sv
test/bridge_tb.sv
